/* Makefile */
TOP := tb_rfm_tracker
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG)

lint:
	verilator --lint-only -Wall +incdir+verilog \
		verilog/rfm_pkg.sv verilog/phase_timer.sv verilog/rfm_ctrl_fsm.sv \
		verilog/row_addr_table.sv verilog/act_count_table.sv verilog/rfm_tracker.sv \
		--top-module rfm_tracker

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
+incdir+verilog
verilog/rfm_pkg.sv
verilog/phase_timer.sv
verilog/rfm_ctrl_fsm.sv
verilog/row_addr_table.sv
verilog/act_count_table.sv
verilog/rfm_tracker.sv
verif/tb_clk_gen.sv
verif/tb_rfm_tracker.sv

/* verif/tb_clk_gen.sv */
module tb_clk_gen (
  output logic clk,
  output logic rstn,
  input  logic reset_req
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // Power-on reset, then again on each request
  initial begin
    rstn = 1'b0;
    forever begin
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rstn = 1'b1;
      @(posedge reset_req);
      rstn = 1'b0;
    end
  end

endmodule

/* verif/tb_rfm_tracker.sv */
`include "rfm_macros.svh"

module tb_rfm_tracker;

  timeunit 1ns;
  timeprecision 100ps;

  import rfm_pkg::*;

  localparam int ACK_LIMIT    = 20;
  localparam int ACK_NEGEDGES = 7;   // Negedges from req until ack is seen
  localparam int RAND_ACTS    = 300;
  localparam int POOL_SIZE    = 24;
  localparam int NUM_TXN      = 1 + 7 + 22 + 5 + RAND_ACTS + RAND_ACTS / 7;

  logic      clk;
  logic      rstn;
  logic      reset_req;
  logic      req;
  cmd_e      cmd;
  row_addr_t addr;
  logic      ack;
  logic      nrr_cmd;
  row_addr_t nrr_addr;

  // Model of the tracker
  row_addr_t m_row [`RFM_NUM_ENTRY];
  act_cnt_t  m_cnt [`RFM_NUM_ENTRY];
  bit        m_valid [`RFM_NUM_ENTRY];
  act_cnt_t  m_spill;
  act_cnt_t  m_max;

  bit        exp_fire_q [$];
  row_addr_t exp_row_q [$];
  row_addr_t obs_row_q [$];
  logic      obs_ack_q [$];
  event      txn_done;

  int        err_cnt;
  int        test_num;
  int        test_err_start;
  int        tests_ok;
  int        tests_bad;
  row_addr_t pool [POOL_SIZE];

  tb_clk_gen u_clk_gen (
    .clk       (clk),
    .rstn      (rstn),
    .reset_req (reset_req)
  );

  rfm_tracker u_dut (
    .clk      (clk),
    .rstn     (rstn),
    .req      (req),
    .cmd      (cmd),
    .addr     (addr),
    .ack      (ack),
    .nrr_cmd  (nrr_cmd),
    .nrr_addr (nrr_addr)
  );

  function automatic void model_clear();
    for (int i = 0; i < `RFM_NUM_ENTRY; i++) begin
      m_row[i]   = '0;
      m_cnt[i]   = '0;
      m_valid[i] = 1'b0;
    end
    m_spill = '0;
    m_max   = '0;
  endfunction

  // Hit, else take a slot at the spillover level, else spill
  function automatic void model_act(input row_addr_t row);
    int idx;
    idx = -1;
    for (int i = 0; i < `RFM_NUM_ENTRY; i++) begin
      if (idx < 0 && m_valid[i] && m_row[i] == row) begin
        idx = i;
      end
    end
    if (idx >= 0) begin
      m_cnt[idx] = act_cnt_t'(m_cnt[idx] + 1);
    end else begin
      for (int i = 0; i < `RFM_NUM_ENTRY; i++) begin
        if (idx < 0 && (!m_valid[i] || m_cnt[i] == m_spill)) begin
          idx = i;
        end
      end
      if (idx >= 0) begin
        m_row[idx]   = row;
        m_valid[idx] = 1'b1;
        m_cnt[idx]   = act_cnt_t'(m_spill + 1);
      end else begin
        m_spill = act_cnt_t'(m_spill + 1);
      end
    end
    if (idx >= 0 && m_cnt[idx] > m_max) begin
      m_max = m_cnt[idx];
    end
  endfunction

  // Expected NRR of one RFM; also updates the model
  function automatic bit expect_rfm(output row_addr_t row);
    int idx;
    idx = -1;
    row = '0;
    for (int i = 0; i < `RFM_NUM_ENTRY; i++) begin
      if (idx < 0 && m_valid[i] && m_cnt[i] == m_max) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      return 1'b0;
    end
    row        = m_row[idx];
    m_cnt[idx] = m_spill;
    m_max      = '0;
    for (int i = 0; i < `RFM_NUM_ENTRY; i++) begin
      if (m_valid[i] && m_cnt[i] > m_max) begin
        m_max = m_cnt[i];
      end
    end
    return 1'b1;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("ERROR: %s", msg);
  endtask

  // One four-phase handshake, req held for extra cycles after ack
  task automatic run_txn(input cmd_e c, input row_addr_t a, input int hold);
    int        waited;
    bit        fire;
    row_addr_t row;
    row = '0;
    if (c == cmd_rfm) begin
      fire = expect_rfm(row);
    end else begin
      model_act(a);
      fire = 1'b0;
    end
    @(posedge clk);
    #1;
    req  = 1'b1;
    cmd  = c;
    addr = a;
    waited = 0;
    while (ack !== 1'b1 && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (ack !== 1'b1) begin
      report_error($sformatf("no ack within %0d cycles for row 0x%0h", ACK_LIMIT, a));
    end else if (waited != ACK_NEGEDGES) begin
      report_error($sformatf("ack rose after %0d cycles instead of %0d", waited,
                             ACK_NEGEDGES));
    end
    repeat (hold) begin
      @(negedge clk);
      if (ack !== 1'b1) begin
        report_error("ack dropped while req was still high");
      end
    end
    @(posedge clk);
    #1;
    req = 1'b0;
    waited = 0;
    while (ack !== 1'b0 && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (ack !== 1'b0) begin
      report_error("ack did not fall after req dropped");
    end
    exp_fire_q.push_back(fire);
    exp_row_q.push_back(row);
    -> txn_done;
  endtask

  task automatic reset_dut();
    @(posedge clk);
    #1;
    reset_req = 1'b1;
    wait (rstn == 1'b0);
    reset_req = 1'b0;
    wait (rstn == 1'b1);
    model_clear();
  endtask

  task automatic begin_test();
    test_num++;
    test_err_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    repeat (2) @(negedge clk);  // Let the compare drain
    if (err_cnt == test_err_start) begin
      tests_ok++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", test_num, name, err_cnt - test_err_start);
    end
  endtask

  // Records every NRR pulse and the ack level beside it
  always @(negedge clk) begin
    if (rstn === 1'b1) begin
      if (nrr_cmd === 1'b1) begin
        obs_row_q.push_back(nrr_addr);
        obs_ack_q.push_back(ack);
      end else begin
        check_val("nrr_addr", 32'(nrr_addr), 32'h0);
      end
    end
  end

  initial begin : compare
    bit        fire;
    row_addr_t row;
    row_addr_t got;
    logic      got_ack;
    forever begin
      @(txn_done);
      while (exp_fire_q.size() > 0) begin
        fire = exp_fire_q.pop_front();
        row  = exp_row_q.pop_front();
        if (fire) begin
          if (obs_row_q.size() == 0) begin
            report_error($sformatf("no NRR pulse for RFM, expected row 0x%0h", row));
          end else begin
            got     = obs_row_q.pop_front();
            got_ack = obs_ack_q.pop_front();
            check_val("nrr_addr", 32'(got), 32'(row));
            if (got_ack !== 1'b0) begin
              report_error("NRR pulse came after ack rose");
            end
          end
        end
        while (obs_row_q.size() > 0) begin
          got = obs_row_q.pop_front();
          void'(obs_ack_q.pop_front());
          report_error($sformatf("unexpected NRR pulse for row 0x%0h", got));
        end
      end
    end
  end

  initial begin : watchdog
    repeat (60 * NUM_TXN) @(posedge clk);
    $display("Timeout: run did not end within %0d cycles", 60 * NUM_TXN);
    $display("Testbench failed");
    $finish;
  end

  initial begin : stimulus
    req       = 1'b0;
    cmd       = cmd_act;
    addr      = '0;
    reset_req = 1'b0;
    err_cnt   = 0;
    test_num  = 0;
    tests_ok  = 0;
    tests_bad = 0;
    void'($urandom(56821));
    model_clear();
    wait (rstn == 1'b1);

    begin_test();
    @(negedge clk);
    check_val("ack", 32'(ack), 32'h0);
    check_val("nrr_cmd", 32'(nrr_cmd), 32'h0);
    check_val("nrr_addr", 32'(nrr_addr), 32'h0);
    run_txn(cmd_rfm, '0, 0);
    end_test("reset state and rfm on empty table");

    begin_test();
    reset_dut();
    repeat (3) run_txn(cmd_act, 18'h01234, 0);
    run_txn(cmd_act, 18'h02222, 0);
    run_txn(cmd_act, 18'h03333, 0);
    repeat (2) run_txn(cmd_rfm, '0, 0);
    end_test("rfm after repeated acts");

    // 16 fill, one spills, two take over slots
    begin_test();
    reset_dut();
    for (int i = 0; i < 19; i++) begin
      run_txn(cmd_act, row_addr_t'(18'h00100 + i), 0);
    end
    repeat (3) run_txn(cmd_rfm, '0, 0);
    end_test("spillover and replacement");

    begin_test();
    reset_dut();
    repeat (2) run_txn(cmd_act, 18'h0aaaa, 3);
    run_txn(cmd_act, 18'h0bbbb, 3);
    repeat (2) run_txn(cmd_rfm, '0, 5);
    end_test("req held after ack");

    begin_test();
    reset_dut();
    foreach (pool[i]) begin
      pool[i] = row_addr_t'($urandom);
    end
    for (int i = 0; i < RAND_ACTS; i++) begin
      run_txn(cmd_act, pool[$urandom_range(POOL_SIZE - 1, 0)], 0);
      if (i % 7 == 6) begin
        run_txn(cmd_rfm, '0, 0);  // Every 8th command
      end
    end
    end_test("random acts with periodic rfm");

    $display("Summary: %0d tests ok, %0d tests with errors, %0d errors total",
             tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verilog/act_count_table.sv */
`include "rfm_macros.svh"

module act_count_table (
  input  logic                clk,
  input  logic                rstn,
  input  logic                cnt_search_spill,
  input  logic                cnt_search_max,
  input  logic                cnt_inc,
  input  logic                cnt_replace,
  input  logic                spill_inc,
  input  logic                cnt_reset,
  input  logic                max_recalc,
  input  rfm_pkg::entry_idx_t hit_idx,
  output logic                cnt_hit,
  output rfm_pkg::entry_idx_t cnt_idx,
  output rfm_pkg::act_cnt_t   rd_cnt,
  output logic                empty
);

  import rfm_pkg::*;

  act_cnt_t                  cnt_mem [`RFM_NUM_ENTRY];
  act_cnt_t                  cnt_nxt [`RFM_NUM_ENTRY];
  logic [`RFM_NUM_ENTRY-1:0] valid;
  act_cnt_t                  spill_cnt;
  act_cnt_t                  max_cnt;
  act_cnt_t                  max_nxt;
  logic                      wr_en;
  entry_idx_t                wr_idx;
  act_cnt_t                  wr_val;
  logic [`RFM_NUM_ENTRY-1:0] srch_match;
  logic                      srch_hit;
  entry_idx_t                srch_idx;

  assign rd_cnt = cnt_mem[hit_idx];  // Count of the row that hit
  assign empty  = ~|valid;

  // New value for the one entry written this cycle
  always_comb begin
    wr_en  = 1'b0;
    wr_idx = hit_idx;
    wr_val = rd_cnt + 1'b1;
    if (cnt_inc) begin
      wr_en = 1'b1;
    end else if (cnt_replace) begin
      wr_en  = 1'b1;
      wr_idx = cnt_idx;
      wr_val = spill_cnt + 1'b1;
    end else if (cnt_reset) begin
      wr_en  = 1'b1;
      wr_idx = cnt_idx;
      wr_val = spill_cnt;
    end
  end

  // Table as it will look after this edge
  always_comb begin
    for (int i = 0; i < `RFM_NUM_ENTRY; i++) begin
      cnt_nxt[i] = (wr_en && (wr_idx == entry_idx_t'(i))) ? wr_val : cnt_mem[i];
    end
  end

  // Max over valid entries, so the reset entry is seen at its new value
  always_comb begin
    max_nxt = '0;
    for (int i = 0; i < `RFM_NUM_ENTRY; i++) begin
      if (valid[i] && (cnt_nxt[i] > max_nxt)) begin
        max_nxt = cnt_nxt[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      cnt_mem[wr_idx] <= wr_val;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (cnt_replace) begin
      valid[cnt_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      spill_cnt <= '0;
      max_cnt   <= '0;
    end else begin
      if (spill_inc) begin
        spill_cnt <= spill_cnt + 1'b1;
      end
      if (max_recalc) begin
        max_cnt <= max_nxt;
      end else if ((cnt_inc || cnt_replace) && (wr_val > max_cnt)) begin
        max_cnt <= wr_val;
      end
    end
  end

  // Empty slots always qualify for a spillover takeover
  always_comb begin
    for (int i = 0; i < `RFM_NUM_ENTRY; i++) begin
      if (cnt_search_max) begin
        srch_match[i] = valid[i] && (cnt_mem[i] == max_cnt);
      end else begin
        srch_match[i] = !valid[i] || (cnt_mem[i] == spill_cnt);
      end
    end
  end

  always_comb begin
    srch_hit = 1'b0;
    srch_idx = '0;
    for (int i = `RFM_NUM_ENTRY - 1; i >= 0; i--) begin
      if (srch_match[i]) begin
        srch_hit = 1'b1;
        srch_idx = entry_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt_hit <= 1'b0;
      cnt_idx <= '0;
    end else if (cnt_search_spill || cnt_search_max) begin
      cnt_hit <= srch_hit;
      cnt_idx <= srch_idx;
    end
  end

  a_spill_le_max: assert property (@(posedge clk) disable iff (!rstn)
    (|valid) |-> (spill_cnt <= max_cnt));

endmodule

/* verilog/phase_timer.sv */
`include "rfm_macros.svh"

module phase_timer (
  input  logic           clk,
  input  logic           rstn,
  input  logic           start,
  output rfm_pkg::step_t step,
  output logic           last_step
);

  import rfm_pkg::*;

  logic  running;
  step_t step_cnt;
  logic  at_end;

  assign at_end = (step_cnt == step_t'(`RFM_NUM_STEP - 1));

  // One pass per command, then park at zero
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      running  <= 1'b0;
      step_cnt <= '0;
    end else if (start) begin
      running  <= 1'b1;
      step_cnt <= '0;
    end else if (running) begin
      if (at_end) begin
        running  <= 1'b0;
        step_cnt <= '0;
      end else begin
        step_cnt <= step_cnt + 1'b1;
      end
    end
  end

  assign step      = step_cnt;
  assign last_step = running && at_end;

endmodule

/* verilog/rfm_ctrl_fsm.sv */
module rfm_ctrl_fsm (
  input  logic           clk,
  input  logic           rstn,
  input  logic           req,
  input  rfm_pkg::cmd_e  cmd,
  input  rfm_pkg::step_t step,
  input  logic           last_step,
  input  logic           addr_hit,
  input  logic           cnt_hit,
  input  logic           empty,
  output logic           ack,
  output logic           start,
  output logic           addr_search,
  output logic           addr_write,
  output logic           addr_read,
  output logic           cnt_search_spill,
  output logic           cnt_search_max,
  output logic           cnt_inc,
  output logic           cnt_replace,
  output logic           spill_inc,
  output logic           cnt_reset,
  output logic           max_recalc,
  output logic           nrr_fire
);

  import rfm_pkg::*;

  fsm_state_e state;
  logic       in_act;
  logic       in_rfm;
  logic       act_decide;

  assign start = (state == st_idle) && req;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= st_idle;
      ack   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req) begin
            state <= (cmd == cmd_rfm) ? st_rfm : st_act;
          end
        end
        st_act, st_rfm: begin
          if (last_step) begin
            state <= st_done;
          end
        end
        st_done: begin
          // Hold ack until the host lets go of req
          if (req) begin
            ack <= 1'b1;
          end else begin
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
      endcase
    end
  end

  assign in_act = (state == st_act);
  assign in_rfm = (state == st_rfm);

  // ACT sequence
  assign addr_search      = in_act && (step == step_t'(0));
  assign cnt_search_spill = in_act && (step == step_t'(1));
  assign act_decide       = in_act && (step == step_t'(2));

  assign cnt_inc     = act_decide && addr_hit;            // Row already tracked
  assign cnt_replace = act_decide && !addr_hit && cnt_hit;
  assign addr_write  = cnt_replace;                       // New row takes the slot
  assign spill_inc   = act_decide && !addr_hit && !cnt_hit;

  // RFM sequence
  assign cnt_search_max = in_rfm && (step == step_t'(0));
  assign addr_read      = in_rfm && (step == step_t'(1)) && cnt_hit && !empty;

  // Fire lands on step 2, together with the count reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      nrr_fire <= 1'b0;
    end else begin
      nrr_fire <= addr_read;
    end
  end

  assign cnt_reset  = nrr_fire;
  assign max_recalc = nrr_fire;

  // Count writes only on the decide step
  a_one_cnt_write: assert property (@(posedge clk) disable iff (!rstn)
    (cnt_inc || cnt_replace || spill_inc || cnt_reset) |->
      ($onehot0({cnt_inc, cnt_replace, spill_inc, cnt_reset}) && (step == step_t'(2))));

endmodule

/* verilog/rfm_macros.svh */
`ifndef RFM_MACROS_SVH
`define RFM_MACROS_SVH

// Table geometry
`define RFM_NUM_ENTRY 16
`define RFM_IDX_W     4

// Row address and activation count widths
`define RFM_ROW_W     18
`define RFM_CNT_W     13

// Timer steps per command
`define RFM_NUM_STEP  4

`endif

/* verilog/rfm_pkg.sv */
`include "rfm_macros.svh"

package rfm_pkg;

  typedef logic [`RFM_ROW_W-1:0] row_addr_t;
  typedef logic [`RFM_CNT_W-1:0] act_cnt_t;   // Activation or spillover count
  typedef logic [`RFM_IDX_W-1:0] entry_idx_t;
  typedef logic [$clog2(`RFM_NUM_STEP)-1:0] step_t;

  typedef enum logic {
    cmd_act = 1'b0,
    cmd_rfm = 1'b1
  } cmd_e;

  // Controller states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_act  = 2'd1,
    st_rfm  = 2'd2,
    st_done = 2'd3
  } fsm_state_e;

endpackage

/* verilog/rfm_tracker.sv */
module rfm_tracker (
  input  logic               clk,
  input  logic               rstn,
  input  logic               req,
  input  rfm_pkg::cmd_e      cmd,
  input  rfm_pkg::row_addr_t addr,
  output logic               ack,
  output logic               nrr_cmd,
  output rfm_pkg::row_addr_t nrr_addr
);

  import rfm_pkg::*;

  row_addr_t  addr_q;
  row_addr_t  rd_addr;
  row_addr_t  rd_addr_q;
  step_t      step;
  entry_idx_t hit_idx;
  entry_idx_t cnt_idx;
  logic       start;
  logic       last_step;
  logic       addr_search;
  logic       addr_write;
  logic       addr_read;
  logic       addr_hit;
  logic       cnt_search_spill;
  logic       cnt_search_max;
  logic       cnt_inc;
  logic       cnt_replace;
  logic       spill_inc;
  logic       cnt_reset;
  logic       max_recalc;
  logic       cnt_hit;
  logic       empty;
  logic       nrr_fire;

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= addr;  // Row of the accepted command
    end
    if (addr_read) begin
      rd_addr_q <= rd_addr;
    end
  end

  // NRR pulse, address zero outside the pulse
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      nrr_cmd  <= 1'b0;
      nrr_addr <= '0;
    end else begin
      nrr_cmd  <= nrr_fire;
      nrr_addr <= nrr_fire ? rd_addr_q : '0;
    end
  end

  rfm_ctrl_fsm u_fsm (
    .clk              (clk),
    .rstn             (rstn),
    .req              (req),
    .cmd              (cmd),
    .step             (step),
    .last_step        (last_step),
    .addr_hit         (addr_hit),
    .cnt_hit          (cnt_hit),
    .empty            (empty),
    .ack              (ack),
    .start            (start),
    .addr_search      (addr_search),
    .addr_write       (addr_write),
    .addr_read        (addr_read),
    .cnt_search_spill (cnt_search_spill),
    .cnt_search_max   (cnt_search_max),
    .cnt_inc          (cnt_inc),
    .cnt_replace      (cnt_replace),
    .spill_inc        (spill_inc),
    .cnt_reset        (cnt_reset),
    .max_recalc       (max_recalc),
    .nrr_fire         (nrr_fire)
  );

  phase_timer u_timer (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .step      (step),
    .last_step (last_step)
  );

  // Replace and RFM both target the slot found by the count search
  row_addr_table u_addr_tbl (
    .clk         (clk),
    .rstn        (rstn),
    .addr_search (addr_search),
    .addr_write  (addr_write),
    .key         (addr_q),
    .wr_idx      (cnt_idx),
    .addr_hit    (addr_hit),
    .hit_idx     (hit_idx),
    .rd_addr     (rd_addr)
  );

  act_count_table u_cnt_tbl (
    .clk              (clk),
    .rstn             (rstn),
    .cnt_search_spill (cnt_search_spill),
    .cnt_search_max   (cnt_search_max),
    .cnt_inc          (cnt_inc),
    .cnt_replace      (cnt_replace),
    .spill_inc        (spill_inc),
    .cnt_reset        (cnt_reset),
    .max_recalc       (max_recalc),
    .hit_idx          (hit_idx),
    .cnt_hit          (cnt_hit),
    .cnt_idx          (cnt_idx),
    .rd_cnt           (),
    .empty            (empty)
  );

  a_nrr_single: assert property (@(posedge clk) disable iff (!rstn)
    nrr_cmd |=> !nrr_cmd);

endmodule

/* verilog/row_addr_table.sv */
`include "rfm_macros.svh"

module row_addr_table (
  input  logic                clk,
  input  logic                rstn,
  input  logic                addr_search,
  input  logic                addr_write,
  input  rfm_pkg::row_addr_t  key,
  input  rfm_pkg::entry_idx_t wr_idx,
  output logic                addr_hit,
  output rfm_pkg::entry_idx_t hit_idx,
  output rfm_pkg::row_addr_t  rd_addr
);

  import rfm_pkg::*;

  row_addr_t                 addr_mem [`RFM_NUM_ENTRY];
  logic [`RFM_NUM_ENTRY-1:0] valid;
  logic                      match_any;
  entry_idx_t                match_idx;

  // Lowest matching valid entry wins
  always_comb begin
    match_any = 1'b0;
    match_idx = '0;
    for (int i = `RFM_NUM_ENTRY - 1; i >= 0; i--) begin
      if (valid[i] && (addr_mem[i] == key)) begin
        match_any = 1'b1;
        match_idx = entry_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      addr_hit <= 1'b0;
      hit_idx  <= '0;
    end else if (addr_search) begin
      addr_hit <= match_any;
      hit_idx  <= match_idx;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (addr_write) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (addr_write) begin
      addr_mem[wr_idx] <= key;
    end
  end

  assign rd_addr = addr_mem[wr_idx];  // NRR row lookup

endmodule
